// File: verilog/rvPkg.sv
package rvPkg;

    localparam int xLen = 32;
    localparam int regAddrW = 5;
    localparam int nRegs = 32;
    localparam int byteEnW = xLen / 8;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        OPIMM  = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcodeT;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASSB   // operand b straight through, used by lui
    } aluOpT;

    // low two bits of funct3 for loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memSizeT;

    typedef enum logic [2:0] {
        EQ  = 3'b000,
        NE  = 3'b001,
        LT  = 3'b100,
        GE  = 3'b101,
        LTU = 3'b110,
        GEU = 3'b111
    } branchCondT;

endpackage

// File: verilog/fetchUnit.sv
module fetchUnit #(
    parameter logic [rvPkg::xLen-1:0] resetPc = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   isJal,
    input  logic                   isJalr,
    input  logic                   isBranch,
    input  logic                   branchTaken,
    input  logic [rvPkg::xLen-1:0] imm,
    input  logic [rvPkg::xLen-1:0] jalrBase,
    output logic [rvPkg::xLen-1:0] pc,
    output logic [rvPkg::xLen-1:0] pcPlus4
);

    logic [rvPkg::xLen-1:0] nextPc;
    logic [rvPkg::xLen-1:0] jalrTarget;

    assign pcPlus4 = pc + rvPkg::xLen'(4);   // also the link value
    assign jalrTarget = jalrBase + imm;

    always_comb begin
        if (isJal || (isBranch && branchTaken)) begin
            nextPc = pc + imm;
        end else if (isJalr) begin
            nextPc = {jalrTarget[rvPkg::xLen-1:1], 1'b0};
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: verilog/instrDecoder.sv
module instrDecoder (
    input  logic [rvPkg::xLen-1:0]     instr,
    input  logic                       reset,
    output logic [rvPkg::regAddrW-1:0] rs1,
    output logic [rvPkg::regAddrW-1:0] rs2,
    output logic [rvPkg::regAddrW-1:0] rd,
    output logic [rvPkg::xLen-1:0]     imm,
    output rvPkg::opcodeT              opcode,
    output rvPkg::aluOpT               aluOp,
    output logic                       useImm,
    output rvPkg::memSizeT             memSize,
    output logic                       loadUnsigned,
    output rvPkg::branchCondT          branchCond,
    output logic                       isJal,
    output logic                       isJalr,
    output logic                       isBranch,
    output logic                       regWrite,
    output logic                       memRead,
    output logic                       memWrite
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [rvPkg::xLen-1:0] immI, immS, immB, immU, immJ;
    logic funct7Zero, funct7Alt;
    rvPkg::aluOpT aluFromFunct;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];
    assign opcode = rvPkg::opcodeT'(instr[6:0]);

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign funct7Zero = (funct7 == 7'b0000000);
    assign funct7Alt = (funct7 == 7'b0100000);

    // bit 30 picks sub (register form only) and sra
    always_comb begin
        case (funct3)
            3'b000: aluFromFunct = (opcode == rvPkg::OP && instr[30]) ? rvPkg::SUB : rvPkg::ADD;
            3'b001: aluFromFunct = rvPkg::SLL;
            3'b010: aluFromFunct = rvPkg::SLT;
            3'b011: aluFromFunct = rvPkg::SLTU;
            3'b100: aluFromFunct = rvPkg::XOR;
            3'b101: aluFromFunct = instr[30] ? rvPkg::SRA : rvPkg::SRL;
            3'b110: aluFromFunct = rvPkg::OR;
            default: aluFromFunct = rvPkg::AND;
        endcase
    end

    always_comb begin
        imm = immI;
        aluOp = rvPkg::ADD;   // address add for loads and stores
        useImm = 1'b0;
        memSize = rvPkg::memSizeT'(funct3[1:0]);
        loadUnsigned = funct3[2];
        branchCond = rvPkg::branchCondT'(funct3);
        isJal = 1'b0;
        isJalr = 1'b0;
        isBranch = 1'b0;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        case (opcode)
            rvPkg::LOAD: begin
                useImm = 1'b1;
                memRead = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
                regWrite = memRead;
            end
            rvPkg::STORE: begin
                imm = immS;
                useImm = 1'b1;
                memWrite = (funct3 inside {3'b000, 3'b001, 3'b010});
            end
            rvPkg::OP: begin
                aluOp = aluFromFunct;
                regWrite = funct7Zero || (funct7Alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rvPkg::OPIMM: begin
                aluOp = aluFromFunct;
                useImm = 1'b1;
                case (funct3)
                    3'b001: regWrite = funct7Zero;
                    3'b101: regWrite = funct7Zero || funct7Alt;
                    default: regWrite = 1'b1;
                endcase
            end
            rvPkg::LUI: begin
                imm = immU;
                aluOp = rvPkg::PASSB;
                useImm = 1'b1;
                regWrite = 1'b1;
            end
            rvPkg::AUIPC: begin
                imm = immU;
                regWrite = 1'b1;
            end
            rvPkg::JAL: begin
                imm = immJ;
                isJal = 1'b1;
                regWrite = 1'b1;
            end
            rvPkg::JALR: begin
                isJalr = (funct3 == 3'b000);
                regWrite = isJalr;
            end
            rvPkg::BRANCH: begin
                imm = immB;
                isBranch = !(funct3 inside {3'b010, 3'b011});
            end
            default: ;   // unknown opcode, nothing happens
        endcase
        if (reset) begin
            isJal = 1'b0;
            isJalr = 1'b0;
            isBranch = 1'b0;
            regWrite = 1'b0;
            memRead = 1'b0;
            memWrite = 1'b0;
        end
    end

endmodule

// File: verilog/regFile.sv
module regFile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [rvPkg::regAddrW-1:0] rs1,
    input  logic [rvPkg::regAddrW-1:0] rs2,
    input  logic [rvPkg::regAddrW-1:0] rd,
    input  logic                       we,
    input  logic [rvPkg::xLen-1:0]     wdata,
    output logic [rvPkg::xLen-1:0]     rv1,
    output logic [rvPkg::xLen-1:0]     rv2
);

    logic [rvPkg::xLen-1:0] regs [rvPkg::nRegs];

    // x0 reads as zero regardless of contents
    assign rv1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rv2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rvPkg::nRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

// File: verilog/execUnit.sv
module execUnit (
    input  logic [rvPkg::xLen-1:0] rv1,
    input  logic [rvPkg::xLen-1:0] rv2,
    input  logic [rvPkg::xLen-1:0] imm,
    input  logic [rvPkg::xLen-1:0] pc,
    input  logic [rvPkg::xLen-1:0] pcPlus4,
    input  rvPkg::aluOpT           aluOp,
    input  logic                   useImm,
    input  rvPkg::opcodeT          opcode,
    input  rvPkg::branchCondT      branchCond,
    output logic [rvPkg::xLen-1:0] result,
    output logic                   branchTaken
);

    logic [rvPkg::xLen-1:0] opB;
    logic [rvPkg::xLen-1:0] aluResult;
    logic [4:0] shamt;
    logic lessSigned, lessUnsigned;

    assign opB = useImm ? imm : rv2;
    assign shamt = opB[4:0];   // only low 5 bits count
    assign lessSigned = $signed(rv1) < $signed(opB);
    assign lessUnsigned = rv1 < opB;

    always_comb begin
        case (aluOp)
            rvPkg::ADD:   aluResult = rv1 + opB;
            rvPkg::SUB:   aluResult = rv1 - opB;
            rvPkg::SLL:   aluResult = rv1 << shamt;
            rvPkg::SLT:   aluResult = {{(rvPkg::xLen-1){1'b0}}, lessSigned};
            rvPkg::SLTU:  aluResult = {{(rvPkg::xLen-1){1'b0}}, lessUnsigned};
            rvPkg::XOR:   aluResult = rv1 ^ opB;
            rvPkg::SRL:   aluResult = rv1 >> shamt;
            rvPkg::SRA:   aluResult = $unsigned($signed(rv1) >>> shamt);
            rvPkg::OR:    aluResult = rv1 | opB;
            rvPkg::AND:   aluResult = rv1 & opB;
            rvPkg::PASSB: aluResult = opB;
            default:      aluResult = '0;
        endcase
    end

    // branches always compare the two registers
    always_comb begin
        case (branchCond)
            rvPkg::EQ:  branchTaken = (rv1 == rv2);
            rvPkg::NE:  branchTaken = (rv1 != rv2);
            rvPkg::LT:  branchTaken = $signed(rv1) < $signed(rv2);
            rvPkg::GE:  branchTaken = $signed(rv1) >= $signed(rv2);
            rvPkg::LTU: branchTaken = rv1 < rv2;
            rvPkg::GEU: branchTaken = rv1 >= rv2;
            default:    branchTaken = 1'b0;
        endcase
    end

    // write-back value, also the data address for loads and stores
    always_comb begin
        case (opcode)
            rvPkg::AUIPC:           result = pc + imm;
            rvPkg::JAL, rvPkg::JALR: result = pcPlus4;
            default:                result = aluResult;   // lui comes through passb
        endcase
    end

endmodule

// File: verilog/loadStoreUnit.sv
module loadStoreUnit (
    input  logic [rvPkg::xLen-1:0]    addr,
    input  logic [rvPkg::xLen-1:0]    storeData,
    input  logic                      memRead,
    input  logic                      memWrite,
    input  rvPkg::memSizeT            memSize,
    input  logic                      loadUnsigned,
    input  logic [rvPkg::xLen-1:0]    drdata,
    output logic [rvPkg::xLen-1:0]    daddr,
    output logic [rvPkg::xLen-1:0]    dwdata,
    output logic [rvPkg::byteEnW-1:0] dwe,
    output logic [rvPkg::xLen-1:0]    loadData,
    output logic                      accessOk
);

    logic aligned;
    logic [rvPkg::xLen-1:0] byteLane, halfLane;
    logic [rvPkg::byteEnW-1:0] laneMask;

    assign daddr = addr;

    always_comb begin
        case (memSize)
            rvPkg::BYTE: aligned = 1'b1;
            rvPkg::HALF: aligned = !addr[0];
            rvPkg::WORD: aligned = (addr[1:0] == 2'b00);
            default:     aligned = 1'b0;
        endcase
    end

    // legal access this cycle
    assign accessOk = aligned && (memRead || memWrite);

    always_comb begin
        case (memSize)
            rvPkg::BYTE: begin
                dwdata = {4{storeData[7:0]}};
                laneMask = 4'b0001 << addr[1:0];
            end
            rvPkg::HALF: begin
                dwdata = {2{storeData[15:0]}};
                laneMask = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dwdata = storeData;
                laneMask = 4'b1111;
            end
        endcase
    end

    assign dwe = (memWrite && aligned) ? laneMask : '0;   // misaligned store does nothing

    assign byteLane = drdata >> {addr[1:0], 3'b000};
    assign halfLane = drdata >> {addr[1], 4'b0000};

    always_comb begin
        case (memSize)
            rvPkg::BYTE: loadData = {{24{!loadUnsigned && byteLane[7]}}, byteLane[7:0]};
            rvPkg::HALF: loadData = {{16{!loadUnsigned && halfLane[15]}}, halfLane[15:0]};
            default:     loadData = drdata;
        endcase
    end

endmodule

// File: verilog/rvCore.sv
module rvCore #(
    parameter logic [rvPkg::xLen-1:0] resetPc = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    output logic [rvPkg::xLen-1:0]    iaddr,
    input  logic [rvPkg::xLen-1:0]    idata,
    output logic [rvPkg::xLen-1:0]    daddr,
    input  logic [rvPkg::xLen-1:0]    drdata,
    output logic [rvPkg::xLen-1:0]    dwdata,
    output logic [rvPkg::byteEnW-1:0] dwe
);

    logic [rvPkg::regAddrW-1:0] rs1, rs2, rd;
    logic [rvPkg::xLen-1:0] imm, rv1, rv2, result, loadData, wbData;
    logic [rvPkg::xLen-1:0] pcPlus4;
    rvPkg::opcodeT opcode;
    rvPkg::aluOpT aluOp;
    rvPkg::memSizeT memSize;
    rvPkg::branchCondT branchCond;
    logic useImm, loadUnsigned;
    logic isJal, isJalr, isBranch, branchTaken;
    logic regWrite, memRead, memWrite, accessOk;
    logic rfWe;

    // loads only write back when the access was legal
    assign rfWe = regWrite && (!memRead || accessOk);
    assign wbData = memRead ? loadData : result;

    fetchUnit #(.resetPc(resetPc)) uFetch (
        .clk(clk), .reset(reset),
        .isJal(isJal), .isJalr(isJalr), .isBranch(isBranch), .branchTaken(branchTaken),
        .imm(imm), .jalrBase(rv1),
        .pc(iaddr), .pcPlus4(pcPlus4)
    );

    instrDecoder uDecode (
        .instr(idata), .reset(reset),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .opcode(opcode), .aluOp(aluOp), .useImm(useImm),
        .memSize(memSize), .loadUnsigned(loadUnsigned), .branchCond(branchCond),
        .isJal(isJal), .isJalr(isJalr), .isBranch(isBranch),
        .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite)
    );

    regFile uRegs (
        .clk(clk), .reset(reset),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(rfWe), .wdata(wbData),
        .rv1(rv1), .rv2(rv2)
    );

    execUnit uExec (
        .rv1(rv1), .rv2(rv2), .imm(imm),
        .pc(iaddr), .pcPlus4(pcPlus4),
        .aluOp(aluOp), .useImm(useImm), .opcode(opcode), .branchCond(branchCond),
        .result(result), .branchTaken(branchTaken)
    );

    loadStoreUnit uLsu (
        .addr(result), .storeData(rv2),
        .memRead(memRead), .memWrite(memWrite),
        .memSize(memSize), .loadUnsigned(loadUnsigned),
        .drdata(drdata),
        .daddr(daddr), .dwdata(dwdata), .dwe(dwe),
        .loadData(loadData), .accessOk(accessOk)
    );

endmodule

// File: sim/rvCore_props.sv
module rvCoreProps (
    input logic                      clk,
    input logic                      reset,
    input logic [rvPkg::xLen-1:0]    iaddr,
    input logic [rvPkg::byteEnW-1:0] dwe
);

    int failures = 0;

    // no store may reach memory in reset
    assert property (@(posedge clk) reset |-> (dwe == '0))
        else begin
            failures++;
            $error("store enable active during reset");
        end

    assert property (@(posedge clk) disable iff (reset) (iaddr[1:0] == 2'b00))
        else begin
            failures++;
            $error("iaddr not word aligned");
        end

    // only whole byte, half and word lanes
    assert property (@(posedge clk) disable iff (reset)
        (dwe inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                     4'b0011, 4'b1100, 4'b1111}))
        else begin
            failures++;
            $error("illegal byte enable pattern");
        end

endmodule

// File: sim/rvCoreTb.sv
module rvCoreTb;

    localparam int period = 4;
    localparam int resetCycles = 10;
    localparam logic [31:0] pcBase = 32'h0000_0100;

    localparam logic [6:0] opImm = 7'b0010011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opJalr = 7'b1100111;
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] nextPc;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] data;
    } stepT;

    logic clk, reset;
    logic [31:0] iaddr, idata, daddr, drdata, dwdata;
    logic [3:0] dwe;
    logic [31:0] dmem [16];   // read-only data memory model
    stepT steps [$];
    logic [31:0] pcModel;
    int checks = 0;
    int errors = 0;

    rvCore #(.resetPc(pcBase)) u_rvCore (
        .clk(clk), .reset(reset),
        .iaddr(iaddr), .idata(idata),
        .daddr(daddr), .drdata(drdata), .dwdata(dwdata), .dwe(dwe)
    );

    bind rvCore rvCoreProps uProps (.clk(clk), .reset(reset), .iaddr(iaddr), .dwe(dwe));

    assign drdata = dmem[daddr[5:2]];

    // instruction encoders with fields in ISA order
    function automatic logic [31:0] rType(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(logic [6:0] op, logic [2:0] f3, logic [4:0] rd, rs1,
                                          logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(logic [2:0] f3, logic [4:0] rs2, rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(logic [2:0] f3, logic [4:0] rs1, rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] uType(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic pushStep(input logic [31:0] instr, nextPc, input logic [3:0] be,
                            input logic [31:0] addr, data);
        steps.push_back('{instr, nextPc, be, addr, data});
        pcModel = nextPc;
    endtask

    task automatic plain(input logic [31:0] instr);
        pushStep(instr, pcModel + 32'd4, 4'b0000, '0, '0);
    endtask

    task automatic jumpTo(input logic [31:0] instr, target);
        pushStep(instr, target, 4'b0000, '0, '0);
    endtask

    task automatic storeStep(input logic [31:0] instr, addr, data, input logic [3:0] be);
        pushStep(instr, pcModel + 32'd4, be, addr, data);
    endtask

    // sw r, 0(x0) exposes a register on dwdata
    task automatic show(input logic [4:0] r, input logic [31:0] value);
        storeStep(sType(3'b010, r, 5'd0, 12'h000), 32'h0, value, 4'b1111);
    endtask

    task automatic compare(input string name, input logic [31:0] actual, expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #1;
        #((steps.size() + resetCycles + 20) * period);
        $display("timeout: core did not get through %0d steps", steps.size());
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] here;
        void'($urandom(32'h3283));
        for (int a = 0; a < 16; a++) begin
            dmem[a] = $urandom;
        end
        dmem[4] |= 32'h8000_8000;   // force negative lanes for sign extension
        dmem[6] |= 32'h8000_8000;
        reset = 1'b1;
        idata = sType(3'b010, 5'd0, 5'd0, 12'h000);   // store held off by reset
        pcModel = pcBase;

        plain(iType(opImm, 3'b000, 5'd1, 5'd0, 12'd5));
        plain(iType(opImm, 3'b000, 5'd2, 5'd0, 12'hFFD));   // x2 = -3
        plain(rType(7'b0100000, 3'b000, 5'd3, 5'd1, 5'd2));
        show(5'd3, 32'd8);
        plain(iType(opImm, 3'b101, 5'd4, 5'd2, 12'h401));   // srai by 1
        show(5'd4, 32'hFFFF_FFFE);
        plain(iType(opImm, 3'b101, 5'd5, 5'd2, 12'd28));
        show(5'd5, 32'h0000_000F);
        plain(rType(7'b0000000, 3'b001, 5'd6, 5'd1, 5'd1));
        show(5'd6, 32'h0000_00A0);
        plain(rType(7'b0000000, 3'b010, 5'd7, 5'd2, 5'd1));
        show(5'd7, 32'd1);
        plain(rType(7'b0000000, 3'b011, 5'd8, 5'd2, 5'd1));
        show(5'd8, 32'd0);
        plain(uType(opLui, 5'd10, 20'hA1B2C));
        plain(iType(opImm, 3'b110, 5'd10, 5'd10, 12'h3D4));
        show(5'd10, 32'hA1B2_C3D4);
        here = pcModel;
        plain(uType(opAuipc, 5'd11, 20'h00001));
        show(5'd11, here + 32'h1000);
        plain(iType(opImm, 3'b000, 5'd0, 5'd1, 12'd7));
        show(5'd0, 32'd0);

        storeStep(sType(3'b000, 5'd10, 5'd0, 12'h020), 32'h20, 32'hD4D4_D4D4, 4'b0001);
        storeStep(sType(3'b000, 5'd10, 5'd0, 12'h021), 32'h21, 32'hD4D4_D4D4, 4'b0010);
        storeStep(sType(3'b000, 5'd10, 5'd0, 12'h022), 32'h22, 32'hD4D4_D4D4, 4'b0100);
        storeStep(sType(3'b000, 5'd10, 5'd0, 12'h023), 32'h23, 32'hD4D4_D4D4, 4'b1000);
        storeStep(sType(3'b001, 5'd10, 5'd0, 12'h024), 32'h24, 32'hC3D4_C3D4, 4'b0011);
        storeStep(sType(3'b001, 5'd10, 5'd0, 12'h026), 32'h26, 32'hC3D4_C3D4, 4'b1100);
        storeStep(sType(3'b010, 5'd10, 5'd0, 12'h028), 32'h28, 32'hA1B2_C3D4, 4'b1111);
        plain(sType(3'b001, 5'd10, 5'd0, 12'h025));   // misaligned half
        plain(sType(3'b010, 5'd10, 5'd0, 12'h02A));   // misaligned word

        plain(iType(opLoad, 3'b000, 5'd20, 5'd0, 12'h011));
        show(5'd20, {{24{dmem[4][15]}}, dmem[4][15:8]});
        plain(iType(opLoad, 3'b100, 5'd21, 5'd0, 12'h013));
        show(5'd21, {24'h0, dmem[4][31:24]});
        plain(iType(opLoad, 3'b001, 5'd22, 5'd0, 12'h01A));
        show(5'd22, {{16{dmem[6][31]}}, dmem[6][31:16]});
        plain(iType(opLoad, 3'b101, 5'd23, 5'd0, 12'h018));
        show(5'd23, {16'h0, dmem[6][15:0]});
        plain(iType(opLoad, 3'b010, 5'd24, 5'd0, 12'h02C));
        show(5'd24, dmem[11]);
        plain(iType(opLoad, 3'b010, 5'd24, 5'd0, 12'h015));   // misaligned so x24 kept
        show(5'd24, dmem[11]);

        // x1 = 5, x2 = -3
        jumpTo(bType(3'b000, 5'd1, 5'd1, 13'h008), pcModel + 32'd8);
        plain(bType(3'b000, 5'd1, 5'd2, 13'h008));
        jumpTo(bType(3'b001, 5'd1, 5'd2, 13'h008), pcModel + 32'd8);
        plain(bType(3'b001, 5'd1, 5'd1, 13'h008));
        jumpTo(bType(3'b100, 5'd2, 5'd1, 13'h008), pcModel + 32'd8);
        plain(bType(3'b100, 5'd1, 5'd2, 13'h008));
        jumpTo(bType(3'b101, 5'd1, 5'd2, 13'h008), pcModel + 32'd8);
        plain(bType(3'b101, 5'd2, 5'd1, 13'h008));
        jumpTo(bType(3'b110, 5'd1, 5'd2, 13'h008), pcModel + 32'd8);
        plain(bType(3'b110, 5'd2, 5'd1, 13'h008));
        jumpTo(bType(3'b111, 5'd2, 5'd1, 13'h1FF4), pcModel - 32'd12);   // backward
        plain(bType(3'b111, 5'd1, 5'd2, 13'h008));

        here = pcModel;
        jumpTo(jType(5'd25, 21'h000040), here + 32'h40);
        show(5'd25, here + 32'd4);
        plain(iType(opImm, 3'b000, 5'd27, 5'd0, 12'h201));
        here = pcModel;
        // target 0x211 with bit 0 cleared
        jumpTo(iType(opJalr, 3'b000, 5'd26, 5'd27, 12'h010), 32'h0000_0210);
        show(5'd26, here + 32'd4);

        plain(iType(7'b1111011, 3'b000, 5'd1, 5'd0, 12'h00A));   // unknown opcode
        plain(iType(opJalr, 3'b001, 5'd1, 5'd27, 12'h010));
        show(5'd1, 32'd5);

        repeat (resetCycles) @(posedge clk);
        #1;
        compare("iaddr", iaddr, pcBase);
        compare("dwe", {28'h0, dwe}, 32'h0);
        @(negedge clk);
        reset = 1'b0;
        foreach (steps[s]) begin
            idata = steps[s].instr;
            #1;
            compare("dwe", {28'h0, dwe}, {28'h0, steps[s].be});
            if (steps[s].be != 4'b0000) begin
                compare("daddr", daddr, steps[s].addr);
                compare("dwdata", dwdata, steps[s].data);
            end
            @(posedge clk);
            #1;
            compare("iaddr", iaddr, steps[s].nextPc);
            @(negedge clk);
        end

        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 u_rvCore.uProps.failures);
        if (errors == 0 && u_rvCore.uProps.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sources.f
verilog/rvPkg.sv
verilog/fetchUnit.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/loadStoreUnit.sv
verilog/rvCore.sv
sim/rvCore_props.sv
sim/rvCoreTb.sv

// File: Bender.yml
package:
  name: rvcore

sources:
  - verilog/rvPkg.sv
  - verilog/fetchUnit.sv
  - verilog/instrDecoder.sv
  - verilog/regFile.sv
  - verilog/execUnit.sv
  - verilog/loadStoreUnit.sv
  - verilog/rvCore.sv
  - target: simulation
    files:
      - sim/rvCore_props.sv
      - sim/rvCoreTb.sv
